// File: tb.f
+incdir+rtl
rtl/sdp_rdma_pkg.sv
rtl/sdp_rdma_cfg_if.sv
rtl/sdp_rdma_regfile.sv
rtl/sdp_rdma_engine.sv
rtl/sdp_rdma_done_ctrl.sv
rtl/sdp_rdma.sv
tests/tb_sdp_rdma.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_sdp_rdma
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed
PASS_MSG  := Simulation passed
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_sdp_rdma.sv
/*
 * sdp read-DMA testbench
 * CSB register access, main and bias engine runs with a memory model,
 * completion status and restart
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_rdma_defs.svh"

module tb_sdp_rdma;

  localparam logic [63:0] DATA_PAT = 64'h5a5a_c3c3_0ff0_a55a;  // memory fill pattern
  localparam int MAX_LINES = 64;
  localparam int WAIT_MAX  = 4000;

  logic nvdla_core_clk;
  logic nvdla_core_rstn = 1'b0;
  logic csb_pvld = 1'b0;
  logic csb_prdy;
  logic [`SDP_RDMA_REG_W+`SDP_RDMA_CSB_ADDR_W:0] csb_pd = '0;
  logic resp_valid;
  logic [`SDP_RDMA_REG_W:0] resp_pd;
  logic [1:0] req_valid;
  logic [1:0] req_ready = '0;
  logic [1:0] rsp_valid = '0;
  logic [1:0] rsp_ready;
  logic [1:0] dp_valid;
  logic [1:0] dp_ready = '0;
  sdp_rdma_pkg::addr_t [1:0] req_pd;
  sdp_rdma_pkg::data_t [1:0] rsp_pd = '0;
  sdp_rdma_pkg::data_t [1:0] dp_pd;
  logic op_done_out;

  // index 0 main engine, 1 bias engine
  sdp_rdma_pkg::addr_t seen_addr [2][MAX_LINES];
  sdp_rdma_pkg::data_t seen_beat [2][MAX_LINES];
  int n_req [2];
  int n_rsp [2];
  int n_beat [2];
  int n_valid [2];
  int done_beats [2];
  int n_done;
  logic bp_on = 1'b0;
  int seed = 32'h17cdb866;
  string cur_test;
  int test_errs;
  int total_errs;
  int tests_run;
  int tests_bad;

  sdp_rdma dut_i (
    .nvdla_core_clk          (nvdla_core_clk),
    .nvdla_core_rstn         (nvdla_core_rstn),
    .csb2sdp_rdma_req_pvld   (csb_pvld),
    .csb2sdp_rdma_req_prdy   (csb_prdy),
    .csb2sdp_rdma_req_pd     (csb_pd),
    .sdp_rdma2csb_resp_valid (resp_valid),
    .sdp_rdma2csb_resp_pd    (resp_pd),
    .sdp2mcif_rd_req_valid   (req_valid[0]),
    .sdp2mcif_rd_req_ready   (req_ready[0]),
    .sdp2mcif_rd_req_pd      (req_pd[0]),
    .mcif2sdp_rd_rsp_valid   (rsp_valid[0]),
    .mcif2sdp_rd_rsp_ready   (rsp_ready[0]),
    .mcif2sdp_rd_rsp_pd      (rsp_pd[0]),
    .sdp_mrdma2cmux_valid    (dp_valid[0]),
    .sdp_mrdma2cmux_ready    (dp_ready[0]),
    .sdp_mrdma2cmux_pd       (dp_pd[0]),
    .sdp_b2mcif_rd_req_valid (req_valid[1]),
    .sdp_b2mcif_rd_req_ready (req_ready[1]),
    .sdp_b2mcif_rd_req_pd    (req_pd[1]),
    .mcif2sdp_b_rd_rsp_valid (rsp_valid[1]),
    .mcif2sdp_b_rd_rsp_ready (rsp_ready[1]),
    .mcif2sdp_b_rd_rsp_pd    (rsp_pd[1]),
    .sdp_brdma2dp_valid      (dp_valid[1]),
    .sdp_brdma2dp_ready      (dp_ready[1]),
    .sdp_brdma2dp_pd         (dp_pd[1]),
    .sdp_rdma_done           (op_done_out)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==================================================
  // memory model and output monitor
  // ==================================================
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      for (int e = 0; e < 2; e++) begin
        if (req_valid[e]) n_valid[e]++;
        if (req_valid[e] && req_ready[e]) begin
          if (n_req[e] < MAX_LINES) seen_addr[e][n_req[e]] = req_pd[e];
          n_req[e]++;
        end
        if (dp_valid[e] && dp_ready[e]) begin
          if (n_beat[e] < MAX_LINES) seen_beat[e][n_beat[e]] = dp_pd[e];
          n_beat[e]++;
        end
        if (rsp_valid[e] && rsp_ready[e]) n_rsp[e]++;
        if (rsp_valid[e] && !rsp_ready[e]) begin
          rsp_valid[e] <= 1'b1;  // hold until taken
        end else if (n_rsp[e] < n_req[e] && n_rsp[e] < MAX_LINES &&
                     (!bp_on || ($random(seed) & 3) != 0)) begin
          rsp_valid[e] <= 1'b1;
          rsp_pd[e]    <= {seen_addr[e][n_rsp[e]], seen_addr[e][n_rsp[e]]} ^ DATA_PAT;
        end else begin
          rsp_valid[e] <= 1'b0;
        end
        req_ready[e] <= !bp_on || ($random(seed) & 1) != 0;
        dp_ready[e]  <= !bp_on || ($random(seed) & 3) != 0;
      end
      if (op_done_out) begin
        n_done++;
        done_beats[0] = n_beat[0];  // beats already out when done fired
        done_beats[1] = n_beat[1];
      end
    end
  end

  // ==================================================
  // reporting and CSB access
  // ==================================================
  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s: %s", cur_test, what);
    test_errs++;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) tests_bad++;
    $display("test %s: %0d errors", cur_test, test_errs);
    test_errs = 0;
  endtask

  task automatic csb_access(input logic wr, input sdp_rdma_pkg::csb_addr_t off,
                            input sdp_rdma_pkg::reg_t wdat, output sdp_rdma_pkg::reg_t rdat);
    int t;
    t    = 0;
    rdat = '0;
    @(posedge nvdla_core_clk);
    csb_pvld <= 1'b1;
    csb_pd   <= {wr, off, wdat};
    do begin
      @(posedge nvdla_core_clk);
      t++;
    end while (!csb_prdy && t < 50);
    csb_pvld <= 1'b0;
    if (!csb_prdy) begin
      report_error("CSB request was never accepted");
    end else begin
      @(posedge nvdla_core_clk);  // response due one cycle after acceptance
      if (!resp_valid) begin
        report_error("no CSB response in the cycle after acceptance");
      end else begin
        if (resp_pd[`SDP_RDMA_REG_W] !== wr)
          report_mismatch("response write flag", 64'(wr), 64'(resp_pd[`SDP_RDMA_REG_W]));
        rdat = resp_pd[`SDP_RDMA_REG_W-1:0];
      end
    end
  endtask

  task automatic csb_write(input sdp_rdma_pkg::csb_addr_t off, input sdp_rdma_pkg::reg_t wdat);
    sdp_rdma_pkg::reg_t rd;
    csb_access(1'b1, off, wdat, rd);
    if (rd !== '0) report_mismatch("write response data", 64'd0, 64'(rd));
  endtask

  task automatic csb_read_check(input sdp_rdma_pkg::csb_addr_t off,
                                input sdp_rdma_pkg::reg_t exp, input string what);
    sdp_rdma_pkg::reg_t rd;
    csb_access(1'b0, off, '0, rd);
    if (rd !== exp) report_mismatch(what, 64'(exp), 64'(rd));
  endtask

  // ==================================================
  // operation helpers
  // ==================================================
  task automatic clear_counts();
    for (int e = 0; e < 2; e++) begin
      n_req[e]      = 0;
      n_rsp[e]      = 0;
      n_beat[e]     = 0;
      n_valid[e]    = 0;
      done_beats[e] = 0;
    end
    n_done = 0;
  endtask

  task automatic run_op(input logic [1:0] dis);
    int t;
    csb_write(`SDP_RDMA_REG_DISABLE, sdp_rdma_pkg::reg_t'(dis));
    csb_write(`SDP_RDMA_REG_STATUS, 32'h1);  // clear status left by an earlier run
    clear_counts();
    csb_write(`SDP_RDMA_REG_OP_EN, 32'h1);
    t = 0;
    while (n_done == 0 && t < WAIT_MAX) begin
      @(posedge nvdla_core_clk);
      t++;
    end
    if (n_done == 0) report_error("sdp_rdma_done did not pulse within the timeout");
    repeat (10) @(posedge nvdla_core_clk);  // window for a second pulse
  endtask

  task automatic check_engine(input int e, input sdp_rdma_pkg::addr_t base,
                              input sdp_rdma_pkg::addr_t stride, input int h);
    sdp_rdma_pkg::addr_t exp_a;
    sdp_rdma_pkg::data_t exp_d;
    string tag;
    tag = (e == 0) ? "main" : "bias";
    if (n_req[e] != h) report_mismatch({tag, " request count"}, 64'(h), 64'(n_req[e]));
    if (n_beat[e] != h) report_mismatch({tag, " beat count"}, 64'(h), 64'(n_beat[e]));
    if (done_beats[e] != h)
      report_mismatch({tag, " beats out at done"}, 64'(h), 64'(done_beats[e]));
    for (int i = 0; i < h && i < MAX_LINES; i++) begin
      exp_a = base + stride * sdp_rdma_pkg::addr_t'(i);
      exp_d = {exp_a, exp_a} ^ DATA_PAT;
      if (i < n_req[e] && seen_addr[e][i] !== exp_a)
        report_mismatch($sformatf("%s address %0d", tag, i), 64'(exp_a), 64'(seen_addr[e][i]));
      if (i < n_beat[e] && seen_beat[e][i] !== exp_d)
        report_mismatch($sformatf("%s beat %0d", tag, i), exp_d, seen_beat[e][i]);
    end
  endtask

  task automatic set_surface(input int e, input sdp_rdma_pkg::addr_t base,
                             input sdp_rdma_pkg::addr_t stride);
    csb_write((e == 0) ? `SDP_RDMA_REG_SRC_BASE : `SDP_RDMA_REG_BS_BASE, base);
    csb_write((e == 0) ? `SDP_RDMA_REG_SRC_STRIDE : `SDP_RDMA_REG_BS_STRIDE, stride);
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    sdp_rdma_pkg::csb_addr_t offs [5];
    sdp_rdma_pkg::reg_t      wv [5];
    sdp_rdma_pkg::reg_t      exp;
    sdp_rdma_pkg::addr_t     m_base;
    sdp_rdma_pkg::addr_t     m_stride;
    sdp_rdma_pkg::addr_t     b_base;
    sdp_rdma_pkg::addr_t     b_stride;
    int                      h;
    test_errs  = 0;
    total_errs = 0;
    tests_run  = 0;
    tests_bad  = 0;
    clear_counts();
    repeat (5) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    cur_test = "reg_access";
    offs[0] = `SDP_RDMA_REG_SRC_BASE;
    offs[1] = `SDP_RDMA_REG_SRC_STRIDE;
    offs[2] = `SDP_RDMA_REG_BS_BASE;
    offs[3] = `SDP_RDMA_REG_BS_STRIDE;
    offs[4] = `SDP_RDMA_REG_HEIGHT;
    for (int i = 0; i < 5; i++) begin
      wv[i] = $random(seed);
      csb_write(offs[i], wv[i]);
    end
    for (int i = 0; i < 5; i++) begin
      exp = wv[i];
      if (i == 4) exp = wv[i] & ((32'h1 << `SDP_RDMA_CNT_W) - 1);  // height is 13 bits
      csb_read_check(offs[i], exp, $sformatf("readback of offset %h", offs[i]));
    end
    csb_read_check(8'h40, '0, "unused offset");
    finish_test();

    cur_test = "main_only";
    h        = 1 + ({$random(seed)} % 16);
    m_base   = $random(seed);
    m_stride = $random(seed) & 32'h0000_ffc0;
    set_surface(0, m_base, m_stride);
    csb_write(`SDP_RDMA_REG_HEIGHT, sdp_rdma_pkg::reg_t'(h));
    bp_on = 1'b0;
    run_op(2'b10);
    check_engine(0, m_base, m_stride, h);
    if (n_done != 1) report_mismatch("done pulse count", 64'd1, 64'(n_done));
    if (n_valid[1] != 0) report_error("disabled bias engine raised a request");
    finish_test();

    cur_test = "both_backpressure";
    h        = 1 + ({$random(seed)} % 16);
    m_base   = $random(seed);
    m_stride = $random(seed) & 32'h0000_ffc0;
    b_base   = $random(seed);
    b_stride = $random(seed) & 32'h0000_ffc0;
    set_surface(0, m_base, m_stride);
    set_surface(1, b_base, b_stride);
    csb_write(`SDP_RDMA_REG_HEIGHT, sdp_rdma_pkg::reg_t'(h));
    bp_on = 1'b1;
    run_op(2'b00);
    bp_on = 1'b0;
    check_engine(0, m_base, m_stride, h);
    check_engine(1, b_base, b_stride, h);
    if (n_done != 1) report_mismatch("done pulse count", 64'd1, 64'(n_done));
    finish_test();

    cur_test = "completion_status";
    csb_read_check(`SDP_RDMA_REG_OP_EN, 32'h0, "op_en after done");
    csb_read_check(`SDP_RDMA_REG_STATUS, 32'h1, "status after done");
    csb_write(`SDP_RDMA_REG_STATUS, 32'h1);
    csb_read_check(`SDP_RDMA_REG_STATUS, 32'h0, "status after clear");
    finish_test();

    cur_test = "both_disabled";
    run_op(2'b11);
    if (n_done != 1) report_mismatch("done pulse count", 64'd1, 64'(n_done));
    if (n_valid[0] != 0 || n_valid[1] != 0) report_error("request valid seen while disabled");
    finish_test();

    cur_test = "restart";
    h        = 1 + ({$random(seed)} % 16);
    m_base   = $random(seed);
    b_base   = $random(seed);
    set_surface(0, m_base, m_stride);
    set_surface(1, b_base, b_stride);
    csb_write(`SDP_RDMA_REG_HEIGHT, sdp_rdma_pkg::reg_t'(h));
    bp_on = 1'b1;
    run_op(2'b00);
    bp_on = 1'b0;
    check_engine(0, m_base, m_stride, h);
    check_engine(1, b_base, b_stride, h);
    if (n_done != 1) report_mismatch("done pulse count", 64'd1, 64'(n_done));
    finish_test();

    $display("tests run %0d, tests with errors %0d, total errors %0d",
             tests_run, tests_bad, total_errs);
    if (total_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/sdp_rdma.sv
/*
 * sdp read-DMA front end
 * register file, main and bias read engines, completion control
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_rdma_defs.svh"

module sdp_rdma (
  input  wire logic                                        nvdla_core_clk,
  input  wire logic                                        nvdla_core_rstn,
  input  wire logic                                        csb2sdp_rdma_req_pvld,
  output logic                                             csb2sdp_rdma_req_prdy,
  input  wire logic [`SDP_RDMA_REG_W+`SDP_RDMA_CSB_ADDR_W:0] csb2sdp_rdma_req_pd,
  output logic                                             sdp_rdma2csb_resp_valid,
  output logic [`SDP_RDMA_REG_W:0]                         sdp_rdma2csb_resp_pd,
  output logic                                             sdp2mcif_rd_req_valid,
  input  wire logic                                        sdp2mcif_rd_req_ready,
  output sdp_rdma_pkg::addr_t                              sdp2mcif_rd_req_pd,
  input  wire logic                                        mcif2sdp_rd_rsp_valid,
  output logic                                             mcif2sdp_rd_rsp_ready,
  input  wire sdp_rdma_pkg::data_t                         mcif2sdp_rd_rsp_pd,
  output logic                                             sdp_mrdma2cmux_valid,
  input  wire logic                                        sdp_mrdma2cmux_ready,
  output sdp_rdma_pkg::data_t                              sdp_mrdma2cmux_pd,
  output logic                                             sdp_b2mcif_rd_req_valid,
  input  wire logic                                        sdp_b2mcif_rd_req_ready,
  output sdp_rdma_pkg::addr_t                              sdp_b2mcif_rd_req_pd,
  input  wire logic                                        mcif2sdp_b_rd_rsp_valid,
  output logic                                             mcif2sdp_b_rd_rsp_ready,
  input  wire sdp_rdma_pkg::data_t                         mcif2sdp_b_rd_rsp_pd,
  output logic                                             sdp_brdma2dp_valid,
  input  wire logic                                        sdp_brdma2dp_ready,
  output sdp_rdma_pkg::data_t                              sdp_brdma2dp_pd,
  output logic                                             sdp_rdma_done
);

  logic reg_op_en;
  logic op_done;
  logic mrdma_disable;
  logic brdma_disable;

  sdp_rdma_cfg_if src_cfg ();  // main surface
  sdp_rdma_cfg_if bs_cfg ();   // bias surface

  // ==================================================
  // config and completion
  // ==================================================
  sdp_rdma_regfile u_reg (
    .nvdla_core_clk          (nvdla_core_clk),
    .nvdla_core_rstn         (nvdla_core_rstn),
    .csb2sdp_rdma_req_pvld   (csb2sdp_rdma_req_pvld),
    .csb2sdp_rdma_req_prdy   (csb2sdp_rdma_req_prdy),
    .csb2sdp_rdma_req_pd     (csb2sdp_rdma_req_pd),
    .sdp_rdma2csb_resp_valid (sdp_rdma2csb_resp_valid),
    .sdp_rdma2csb_resp_pd    (sdp_rdma2csb_resp_pd),
    .op_done                 (op_done),
    .op_en                   (reg_op_en),
    .mrdma_disable           (mrdma_disable),
    .brdma_disable           (brdma_disable),
    .src_cfg                 (src_cfg),
    .bs_cfg                  (bs_cfg)
  );

  sdp_rdma_done_ctrl u_done (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_op_en       (reg_op_en),
    .mrdma_disable   (mrdma_disable),
    .brdma_disable   (brdma_disable),
    .src_cfg         (src_cfg),
    .bs_cfg          (bs_cfg),
    .op_done         (op_done)
  );

  assign sdp_rdma_done = op_done;

  // ==================================================
  // read engines
  // ==================================================
  sdp_rdma_engine u_mrdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (src_cfg),
    .rd_req_valid    (sdp2mcif_rd_req_valid),
    .rd_req_ready    (sdp2mcif_rd_req_ready),
    .rd_req_pd       (sdp2mcif_rd_req_pd),
    .rd_rsp_valid    (mcif2sdp_rd_rsp_valid),
    .rd_rsp_ready    (mcif2sdp_rd_rsp_ready),
    .rd_rsp_pd       (mcif2sdp_rd_rsp_pd),
    .dp_valid        (sdp_mrdma2cmux_valid),
    .dp_ready        (sdp_mrdma2cmux_ready),
    .dp_pd           (sdp_mrdma2cmux_pd)
  );

  sdp_rdma_engine u_brdma (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cfg             (bs_cfg),
    .rd_req_valid    (sdp_b2mcif_rd_req_valid),
    .rd_req_ready    (sdp_b2mcif_rd_req_ready),
    .rd_req_pd       (sdp_b2mcif_rd_req_pd),
    .rd_rsp_valid    (mcif2sdp_b_rd_rsp_valid),
    .rd_rsp_ready    (mcif2sdp_b_rd_rsp_ready),
    .rd_rsp_pd       (mcif2sdp_b_rd_rsp_pd),
    .dp_valid        (sdp_brdma2dp_valid),
    .dp_ready        (sdp_brdma2dp_ready),
    .dp_pd           (sdp_brdma2dp_pd)
  );

endmodule

`default_nettype wire

// File: rtl/sdp_rdma_done_ctrl.sv
/*
 * completion controller
 * done-pending flags, per-engine enable gating, operation done
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_rdma_defs.svh"

module sdp_rdma_done_ctrl (
  input  wire logic     nvdla_core_clk,
  input  wire logic     nvdla_core_rstn,
  input  wire logic     reg_op_en,
  input  wire logic     mrdma_disable,
  input  wire logic     brdma_disable,
  sdp_rdma_cfg_if.ctrl  src_cfg,
  sdp_rdma_cfg_if.ctrl  bs_cfg,
  output logic          op_done
);

  logic [`SDP_RDMA_ENG_NUM-1:0] pending;
  logic [`SDP_RDMA_ENG_NUM-1:0] eng_done;
  logic [`SDP_RDMA_ENG_NUM-1:0] eng_dis;

  assign eng_done = {bs_cfg.done, src_cfg.done};  // bit0 main, bit1 bias
  assign eng_dis  = {brdma_disable, mrdma_disable};

  // disabled engine counts as finished
  assign op_done = reg_op_en & (&(pending | eng_done | eng_dis));

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pending <= '0;
    end else if (op_done) begin
      pending <= '0;
    end else begin
      pending <= pending | eng_done;
    end
  end

  assign src_cfg.op_en = reg_op_en & ~pending[0] & ~mrdma_disable;
  assign bs_cfg.op_en  = reg_op_en & ~pending[1] & ~brdma_disable;

  done_not_pending: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (eng_done & pending) == '0);

endmodule

`default_nettype wire

// File: rtl/sdp_rdma_engine.sv
/*
 * line read engine
 * issues one request per line, forwards in-order responses, flags completion
 */
`timescale 1ns/1ps
`default_nettype none

module sdp_rdma_engine (
  input  wire logic                 nvdla_core_clk,
  input  wire logic                 nvdla_core_rstn,
  sdp_rdma_cfg_if.engine            cfg,
  output logic                      rd_req_valid,
  input  wire logic                 rd_req_ready,
  output sdp_rdma_pkg::addr_t       rd_req_pd,
  input  wire logic                 rd_rsp_valid,
  output logic                      rd_rsp_ready,
  input  wire sdp_rdma_pkg::data_t  rd_rsp_pd,
  output logic                      dp_valid,
  input  wire logic                 dp_ready,
  output sdp_rdma_pkg::data_t       dp_pd
);

  sdp_rdma_pkg::engine_state_t state;
  sdp_rdma_pkg::addr_t         req_addr;
  sdp_rdma_pkg::cnt_t          req_cnt;   // requests issued
  sdp_rdma_pkg::cnt_t          rsp_cnt;   // beats forwarded
  sdp_rdma_pkg::cnt_t          last_idx;
  logic                        start;
  logic                        req_acc;
  logic                        dp_acc;
  logic                        last_req;
  logic                        last_beat;

  assign start     = (state == sdp_rdma_pkg::ENG_IDLE) & cfg.op_en;
  assign last_idx  = cfg.height - 1'b1;
  assign req_acc   = rd_req_valid & rd_req_ready;
  assign dp_acc    = (state == sdp_rdma_pkg::ENG_RUN) & rd_rsp_valid & dp_ready;
  assign last_req  = req_cnt == last_idx;
  assign last_beat = dp_acc & (rsp_cnt == last_idx);

  // ==================================================
  // state and counters
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state        <= sdp_rdma_pkg::ENG_IDLE;
      rd_req_valid <= 1'b0;
      req_cnt      <= '0;
      rsp_cnt      <= '0;
    end else begin
      case (state)
        sdp_rdma_pkg::ENG_IDLE: begin
          if (cfg.op_en) begin
            state        <= sdp_rdma_pkg::ENG_RUN;
            rd_req_valid <= 1'b1;
            req_cnt      <= '0;
            rsp_cnt      <= '0;
          end
        end
        sdp_rdma_pkg::ENG_RUN: begin
          if (req_acc) begin
            req_cnt <= req_cnt + 1'b1;
            if (last_req) rd_req_valid <= 1'b0;  // all lines issued
          end
          if (dp_acc) rsp_cnt <= rsp_cnt + 1'b1;
          if (last_beat) state <= sdp_rdma_pkg::ENG_IDLE;
        end
        default: state <= sdp_rdma_pkg::ENG_IDLE;
      endcase
    end
  end

  // running line address
  always_ff @(posedge nvdla_core_clk) begin
    if (start) begin
      req_addr <= cfg.base_addr;
    end else if (req_acc) begin
      req_addr <= req_addr + cfg.line_stride;
    end
  end

  assign rd_req_pd    = req_addr;
  assign rd_rsp_ready = dp_ready;     // datapath stall holds memory
  assign dp_valid     = rd_rsp_valid;
  assign dp_pd        = rd_rsp_pd;
  assign cfg.done     = last_beat;

  start_height_nz: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    start |-> cfg.height != '0);

  req_pd_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (rd_req_valid && !rd_req_ready) |=> (rd_req_valid && $stable(rd_req_pd)));

endmodule

`default_nettype wire

// File: rtl/sdp_rdma_regfile.sv
/*
 * sdp read-DMA register file
 * CSB decode, one registered response per request, op_en and status
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_rdma_defs.svh"

module sdp_rdma_regfile (
  input  wire logic                                        nvdla_core_clk,
  input  wire logic                                        nvdla_core_rstn,
  input  wire logic                                        csb2sdp_rdma_req_pvld,
  output logic                                             csb2sdp_rdma_req_prdy,
  input  wire logic [`SDP_RDMA_REG_W+`SDP_RDMA_CSB_ADDR_W:0] csb2sdp_rdma_req_pd,
  output logic                                             sdp_rdma2csb_resp_valid,
  output logic [`SDP_RDMA_REG_W:0]                         sdp_rdma2csb_resp_pd,
  input  wire logic                                        op_done,
  output logic                                             op_en,
  output logic                                             mrdma_disable,
  output logic                                             brdma_disable,
  sdp_rdma_cfg_if.regs                                     src_cfg,
  sdp_rdma_cfg_if.regs                                     bs_cfg
);

  logic                    req_acc;
  logic                    req_wr;
  sdp_rdma_pkg::csb_addr_t req_addr;
  sdp_rdma_pkg::reg_t      req_wdat;
  sdp_rdma_pkg::reg_t      rd_data;
  logic                    status_done;
  sdp_rdma_pkg::addr_t     src_base;
  sdp_rdma_pkg::addr_t     src_stride;
  sdp_rdma_pkg::addr_t     bs_base;
  sdp_rdma_pkg::addr_t     bs_stride;
  sdp_rdma_pkg::cnt_t      height;

  // {wr, offset, wdata}
  assign req_wr   = csb2sdp_rdma_req_pd[`SDP_RDMA_REG_W+`SDP_RDMA_CSB_ADDR_W];
  assign req_addr = csb2sdp_rdma_req_pd[`SDP_RDMA_REG_W +: `SDP_RDMA_CSB_ADDR_W];
  assign req_wdat = csb2sdp_rdma_req_pd[`SDP_RDMA_REG_W-1:0];
  assign req_acc  = csb2sdp_rdma_req_pvld & csb2sdp_rdma_req_prdy;

  // ==================================================
  // register writes
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csb2sdp_rdma_req_prdy <= 1'b0;
      op_en                 <= 1'b0;
      status_done           <= 1'b0;
      mrdma_disable         <= 1'b0;
      brdma_disable         <= 1'b0;
      src_base              <= '0;
      src_stride            <= '0;
      bs_base               <= '0;
      bs_stride             <= '0;
      height                <= '0;
    end else begin
      csb2sdp_rdma_req_prdy <= !req_acc;  // one request per two cycles
      if (op_done) begin
        op_en       <= 1'b0;
        status_done <= 1'b1;
      end
      if (req_acc && req_wr) begin
        case (req_addr)
          `SDP_RDMA_REG_OP_EN:      if (req_wdat[0]) op_en <= 1'b1;
          `SDP_RDMA_REG_STATUS:     if (req_wdat[0] && !op_done) status_done <= 1'b0;  // w1c
          `SDP_RDMA_REG_DISABLE: begin
            mrdma_disable <= req_wdat[0];
            brdma_disable <= req_wdat[1];
          end
          `SDP_RDMA_REG_SRC_BASE:   src_base   <= req_wdat;
          `SDP_RDMA_REG_SRC_STRIDE: src_stride <= req_wdat;
          `SDP_RDMA_REG_BS_BASE:    bs_base    <= req_wdat;
          `SDP_RDMA_REG_BS_STRIDE:  bs_stride  <= req_wdat;
          `SDP_RDMA_REG_HEIGHT:     height     <= req_wdat[`SDP_RDMA_CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // read mux, unknown offsets read as zero
  always_comb begin
    case (req_addr)
      `SDP_RDMA_REG_OP_EN:      rd_data = sdp_rdma_pkg::reg_t'(op_en);
      `SDP_RDMA_REG_STATUS:     rd_data = sdp_rdma_pkg::reg_t'(status_done);
      `SDP_RDMA_REG_DISABLE:    rd_data = sdp_rdma_pkg::reg_t'({brdma_disable, mrdma_disable});
      `SDP_RDMA_REG_SRC_BASE:   rd_data = src_base;
      `SDP_RDMA_REG_SRC_STRIDE: rd_data = src_stride;
      `SDP_RDMA_REG_BS_BASE:    rd_data = bs_base;
      `SDP_RDMA_REG_BS_STRIDE:  rd_data = bs_stride;
      `SDP_RDMA_REG_HEIGHT:     rd_data = sdp_rdma_pkg::reg_t'(height);
      default:                  rd_data = '0;
    endcase
  end

  // ==================================================
  // response
  // ==================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      sdp_rdma2csb_resp_valid <= 1'b0;
    end else begin
      sdp_rdma2csb_resp_valid <= req_acc;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_acc) begin
      sdp_rdma2csb_resp_pd <= req_wr ? {1'b1, sdp_rdma_pkg::reg_t'(0)} : {1'b0, rd_data};
    end
  end

  assign src_cfg.base_addr   = src_base;
  assign src_cfg.line_stride = src_stride;
  assign src_cfg.height      = height;    // height shared by both surfaces
  assign bs_cfg.base_addr    = bs_base;
  assign bs_cfg.line_stride  = bs_stride;
  assign bs_cfg.height       = height;

  resp_single_cycle: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    sdp_rdma2csb_resp_valid |=> !sdp_rdma2csb_resp_valid);

endmodule

`default_nettype wire

// File: rtl/sdp_rdma_cfg_if.sv
/*
 * per-engine config bundle
 * surface settings from the register file, enable and done handshake
 */
`timescale 1ns/1ps
`default_nettype none

interface sdp_rdma_cfg_if;

  sdp_rdma_pkg::addr_t base_addr;    // first line address
  sdp_rdma_pkg::addr_t line_stride;  // bytes between lines
  sdp_rdma_pkg::cnt_t  height;       // lines to fetch
  logic                op_en;        // gated enable
  logic                done;         // one-cycle completion pulse

  modport regs (
    output base_addr, line_stride, height
  );

  modport ctrl (
    output op_en,
    input  done
  );

  modport engine (
    input  base_addr, line_stride, height, op_en,
    output done
  );

endinterface

`default_nettype wire

// File: rtl/sdp_rdma_pkg.sv
/*
 * sdp read-DMA types
 * vector typedefs and the engine state encoding
 */
`default_nettype none

`include "sdp_rdma_defs.svh"

package sdp_rdma_pkg;

  typedef logic [`SDP_RDMA_ADDR_W-1:0]     addr_t;      // byte address
  typedef logic [`SDP_RDMA_DATA_W-1:0]     data_t;      // one beat
  typedef logic [`SDP_RDMA_CNT_W-1:0]      cnt_t;       // line count / index
  typedef logic [`SDP_RDMA_CSB_ADDR_W-1:0] csb_addr_t;  // register offset
  typedef logic [`SDP_RDMA_REG_W-1:0]      reg_t;       // register value

  // read engine FSM
  typedef enum logic {
    ENG_IDLE = 1'b0,
    ENG_RUN  = 1'b1
  } engine_state_t;

endpackage

`default_nettype wire

// File: rtl/sdp_rdma_defs.svh
/*
 * sdp read-DMA shared constants
 * widths, CSB register offsets and engine count
 */
`ifndef SDP_RDMA_DEFS_SVH
`define SDP_RDMA_DEFS_SVH

`define SDP_RDMA_ADDR_W         32     // memory byte address
`define SDP_RDMA_DATA_W         64     // response / datapath beat
`define SDP_RDMA_CNT_W          13     // line count, as for height
`define SDP_RDMA_CSB_ADDR_W     8      // register offset
`define SDP_RDMA_REG_W          32     // register data
`define SDP_RDMA_ENG_NUM        2      // main + bias

`define SDP_RDMA_REG_OP_EN      8'h00
`define SDP_RDMA_REG_STATUS     8'h04
`define SDP_RDMA_REG_DISABLE    8'h08  // bit0 main, bit1 bias
`define SDP_RDMA_REG_SRC_BASE   8'h0C
`define SDP_RDMA_REG_SRC_STRIDE 8'h10
`define SDP_RDMA_REG_BS_BASE    8'h14
`define SDP_RDMA_REG_BS_STRIDE  8'h18
`define SDP_RDMA_REG_HEIGHT     8'h1C

`endif
